//--- bus_control/bus_control.sv
`timescale 1ns/1ps
`default_nettype none

module bus_control (
	input logic CLK,
	input logic nRST,
	cache_port_if.seq c0,
	cache_port_if.seq c1,
	mem_port_if.ctrl mem,
	input logic requester,
	input logic pending,
	input bus_pkg::txn_t txn,
	output logic capture,
	output logic complete,
	output logic served
);
	import bus_pkg::*;

	localparam int CNT_W = (BLOCK_WORDS > 1) ? $clog2(BLOCK_WORDS) : 1;

	bus_state_t state, next_state;
	txn_t txn_q, next_txn;
	logic next_served;
	logic [CNT_W-1:0] wb_cnt, next_wb_cnt;

	logic [CACHES-1:0] dwait_v;
	logic [CACHES-1:0] ccinv_v;
	logic [CACHES-1:0] ccwait_v;

	word_t srv_daddr;
	word_t oth_daddr;
	word_t oth_dstore;
	logic oth_cctrans;

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			state <= IDLE;
			served <= 1'b0;
			txn_q <= TXN_NONE;
			wb_cnt <= '0;
		end else begin
			state <= next_state;
			served <= next_served;
			txn_q <= next_txn;
			wb_cnt <= next_wb_cnt;
		end
	end

	// served cache and the one being snooped
	assign srv_daddr = served ? c1.daddr : c0.daddr;
	assign oth_daddr = served ? c0.daddr : c1.daddr;
	assign oth_dstore = served ? c0.dstore : c1.dstore;
	assign oth_cctrans = served ? c0.cctrans : c1.cctrans;

	always_comb begin
		next_state = state;
		next_served = served;
		next_txn = txn_q;
		next_wb_cnt = wb_cnt;

		dwait_v = '1;
		ccinv_v = '0;
		ccwait_v = '0;

		mem.dREN = 1'b0;
		mem.dWEN = 1'b0;
		mem.daddr = srv_daddr;
		mem.dstore = '0;

		capture = 1'b0;
		complete = 1'b0;

		// the other cache stalls for the whole transaction
		if (state != IDLE) begin
			ccwait_v[~served] = 1'b1;
		end

		case (state)
			IDLE: begin
				if (pending) begin
					next_served = requester;
					next_txn = txn;
					next_wb_cnt = '0;
					if (txn == TXN_WRITEBACK) begin
						next_state = MEM_WB;
					end else begin
						next_state = SNOOP;
					end
				end
			end

			SNOOP: begin
				if (oth_cctrans) begin
					next_state = MOD_WB;
				end else if (txn_q == TXN_INVALIDATE) begin
					// nobody holds it dirty, invalidate and release at once
					ccinv_v[~served] = 1'b1;
					dwait_v[served] = 1'b0;
					next_state = IDLE;
				end else if (txn_q == TXN_READ) begin
					next_state = MEM_READ;
				end else begin
					next_state = IDLE;
				end
			end

			MEM_WB: begin
				mem.dWEN = 1'b1;
				mem.dstore = served ? c1.dstore : c0.dstore;
				if (!mem.dwait) begin
					dwait_v[served] = 1'b0;
					next_state = IDLE;
				end
			end

			MOD_WB: begin
				// flush the snooped block word by word
				mem.dWEN = 1'b1;
				mem.daddr = oth_daddr;
				mem.dstore = oth_dstore;
				if (!mem.dwait) begin
					dwait_v[~served] = 1'b0;
					if (wb_cnt == CNT_W'(BLOCK_WORDS - 1)) begin
						ccinv_v[~served] = 1'b1;
						next_wb_cnt = '0;
						if (txn_q == TXN_READ) begin
							next_state = MEM_READ;
						end else begin
							dwait_v[served] = 1'b0;
							next_state = IDLE;
						end
					end else begin
						next_wb_cnt = wb_cnt + 1'b1;
					end
				end
			end

			MEM_READ: begin
				mem.dREN = 1'b1;
				if (!mem.dwait) begin
					capture = 1'b1;
					next_state = COMPLETE;
				end
			end

			COMPLETE: begin
				// reply unit releases the requester with the read word
				complete = 1'b1;
				next_state = IDLE;
			end

			default: begin
				next_state = IDLE;
			end
		endcase
	end

	assign c0.dwait = dwait_v[0];
	assign c1.dwait = dwait_v[1];
	assign c0.ccinv = ccinv_v[0];
	assign c1.ccinv = ccinv_v[1];
	assign c0.ccwait = ccwait_v[0];
	assign c1.ccwait = ccwait_v[1];

	// both caches watch the same snoop address
	assign c0.ccsnoopaddr = srv_daddr;
	assign c1.ccsnoopaddr = srv_daddr;

	a_mem_strobes: assert property (
		@(posedge CLK) disable iff (!nRST)
		!(mem.dREN && mem.dWEN)
	) else $error("memory read and write strobes high together");

	a_ccinv_target: assert property (
		@(posedge CLK) disable iff (!nRST)
		(state != IDLE) |-> !ccinv_v[served]
	) else $error("ccinv raised toward the served cache %0d", served);

endmodule

`default_nettype wire

//--- bus_control/bus_reply.sv
`timescale 1ns/1ps
`default_nettype none

module bus_reply (
	input logic CLK,
	input logic nRST,
	input logic capture,
	input logic complete,
	input logic served,
	input bus_pkg::word_t mem_dload,
	output bus_pkg::word_t dload0,
	output bus_pkg::word_t dload1,
	output logic rdone0,
	output logic rdone1
);
	import bus_pkg::*;

	word_t rd_word;
	logic held;

	always_ff @(posedge CLK) begin
		if (capture) begin
			rd_word <= mem_dload;
		end
	end

	// a word is waiting between capture and COMPLETE
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			held <= 1'b0;
		end else if (capture) begin
			held <= 1'b1;
		end else if (complete) begin
			held <= 1'b0;
		end
	end

	assign rdone0 = complete & held & ~served;
	assign rdone1 = complete & held & served;

	// only the served cache sees the word
	assign dload0 = rdone0 ? rd_word : '0;
	assign dload1 = rdone1 ? rd_word : '0;

	a_complete_after_capture: assert property (
		@(posedge CLK) disable iff (!nRST)
		complete |-> held
	) else $error("COMPLETE reached without a captured read word");

endmodule

`default_nettype wire

//--- bus_control/bus_request_decode.sv
`timescale 1ns/1ps
`default_nettype none

module bus_request_decode (
	cache_port_if.decode c0,
	cache_port_if.decode c1,
	output logic requester,
	output bus_pkg::txn_t txn,
	output logic pending
);
	import bus_pkg::*;

	logic [2:0] strobes0;
	logic [2:0] strobes1;
	logic req0;
	logic req1;
	logic win_ren;
	logic win_wen;
	logic win_ccwrite;

	assign strobes0 = {c0.dREN, c0.dWEN, c0.ccwrite};
	assign strobes1 = {c1.dREN, c1.dWEN, c1.ccwrite};

	assign req0 = |strobes0;
	assign req1 = |strobes1;

	// cache 0 always wins a tie
	assign pending = req0 | req1;
	assign requester = ~req0;

	assign win_ren = requester ? c1.dREN : c0.dREN;
	assign win_wen = requester ? c1.dWEN : c0.dWEN;
	assign win_ccwrite = requester ? c1.ccwrite : c0.ccwrite;

	always_comb begin
		if (win_ren) begin
			txn = TXN_READ;
		end else if (win_ccwrite) begin
			txn = TXN_INVALIDATE;
		end else if (win_wen) begin
			txn = TXN_WRITEBACK;
		end else begin
			txn = TXN_NONE;
		end
	end

	// a cache asks for one thing at a time
	always_comb begin
		assert ($isunknown(strobes0) || $onehot0(strobes0))
		else $error("cache 0 raised more than one request strobe: %b", strobes0);
		assert ($isunknown(strobes1) || $onehot0(strobes1))
		else $error("cache 1 raised more than one request strobe: %b", strobes1);
	end

endmodule

`default_nettype wire

//--- common/bus_pkg.sv
`default_nettype none

package bus_pkg;

	// data and address word on both sides of the controller
	typedef logic [31:0] word_t;

	// number of caches sharing the bus
	localparam int CACHES = 2;

	// words moved when a snooped cache flushes its modified block
	localparam int BLOCK_WORDS = 2;

	// sequencer states
	typedef enum logic [2:0] {
		IDLE,
		SNOOP,
		MEM_WB,
		MOD_WB,
		MEM_READ,
		COMPLETE
	} bus_state_t;

	// kind of request picked by the decoder
	typedef enum logic [1:0] {
		TXN_NONE,
		TXN_READ,
		TXN_WRITEBACK,
		TXN_INVALIDATE
	} txn_t;

endpackage

`default_nettype wire

//--- common/cache_port_if.sv
`timescale 1ns/1ps
`default_nettype none

interface cache_port_if;
	import bus_pkg::*;

	// request side, driven by the cache
	logic dREN;
	logic dWEN;
	logic ccwrite;
	logic cctrans;
	word_t daddr;
	word_t dstore;

	// reply side, driven by the controller
	logic dwait;
	word_t dload;
	logic ccwait;
	logic ccinv;
	word_t ccsnoopaddr;

	modport cache (
		output dREN, dWEN, ccwrite, cctrans, daddr, dstore,
		input dwait, dload, ccwait, ccinv, ccsnoopaddr
	);

	// request strobes are all the decoder needs
	modport decode (
		input dREN, dWEN, ccwrite
	);

	// dload comes from the reply unit, not from the sequencer
	modport seq (
		input dREN, dWEN, ccwrite, cctrans, daddr, dstore,
		output dwait, ccwait, ccinv, ccsnoopaddr
	);

endinterface

`default_nettype wire

//--- common/mem_port_if.sv
`timescale 1ns/1ps
`default_nettype none

interface mem_port_if;
	import bus_pkg::*;

	logic dREN;
	logic dWEN;
	word_t daddr;
	word_t dstore;
	word_t dload;
	// held high until the memory accepts a write or has read data
	logic dwait;

	modport ctrl (
		output dREN, dWEN, daddr, dstore,
		input dload, dwait
	);

	modport mem (
		input dREN, dWEN, daddr, dstore,
		output dload, dwait
	);

endinterface

`default_nettype wire

//--- list.f
common/bus_pkg.sv
common/cache_port_if.sv
common/mem_port_if.sv
bus_control/bus_request_decode.sv
bus_control/bus_control.sv
bus_control/bus_reply.sv
rtl/coherence_bus_top.sv
sim/tb_coherence_bus.sv

//--- rtl/coherence_bus_top.sv
`timescale 1ns/1ps
`default_nettype none

module coherence_bus_top (
	input logic CLK,
	input logic nRST,

	input logic dREN0,
	input logic dWEN0,
	input logic ccwrite0,
	input logic cctrans0,
	input bus_pkg::word_t daddr0,
	input bus_pkg::word_t dstore0,
	output logic dwait0,
	output bus_pkg::word_t dload0,
	output logic ccwait0,
	output logic ccinv0,
	output bus_pkg::word_t ccsnoopaddr0,

	input logic dREN1,
	input logic dWEN1,
	input logic ccwrite1,
	input logic cctrans1,
	input bus_pkg::word_t daddr1,
	input bus_pkg::word_t dstore1,
	output logic dwait1,
	output bus_pkg::word_t dload1,
	output logic ccwait1,
	output logic ccinv1,
	output bus_pkg::word_t ccsnoopaddr1,

	output logic mem_dREN,
	output logic mem_dWEN,
	output bus_pkg::word_t mem_daddr,
	output bus_pkg::word_t mem_dstore,
	input bus_pkg::word_t mem_dload,
	input logic mem_dwait
);
	import bus_pkg::*;

	cache_port_if cp [CACHES] ();
	mem_port_if mif ();

	logic requester;
	logic pending;
	txn_t txn;
	logic capture;
	logic complete;
	logic served;
	logic rdone0;
	logic rdone1;
	word_t rep_dload0;
	word_t rep_dload1;

	assign cp[0].dREN = dREN0;
	assign cp[0].dWEN = dWEN0;
	assign cp[0].ccwrite = ccwrite0;
	assign cp[0].cctrans = cctrans0;
	assign cp[0].daddr = daddr0;
	assign cp[0].dstore = dstore0;
	assign cp[0].dload = rep_dload0;

	assign cp[1].dREN = dREN1;
	assign cp[1].dWEN = dWEN1;
	assign cp[1].ccwrite = ccwrite1;
	assign cp[1].cctrans = cctrans1;
	assign cp[1].daddr = daddr1;
	assign cp[1].dstore = dstore1;
	assign cp[1].dload = rep_dload1;

	// read release from the reply unit joins the sequencer's dwait
	assign dwait0 = cp[0].dwait & ~rdone0;
	assign dwait1 = cp[1].dwait & ~rdone1;

	assign dload0 = cp[0].dload;
	assign ccwait0 = cp[0].ccwait;
	assign ccinv0 = cp[0].ccinv;
	assign ccsnoopaddr0 = cp[0].ccsnoopaddr;

	assign dload1 = cp[1].dload;
	assign ccwait1 = cp[1].ccwait;
	assign ccinv1 = cp[1].ccinv;
	assign ccsnoopaddr1 = cp[1].ccsnoopaddr;

	assign mem_dREN = mif.dREN;
	assign mem_dWEN = mif.dWEN;
	assign mem_daddr = mif.daddr;
	assign mem_dstore = mif.dstore;
	assign mif.dload = mem_dload;
	assign mif.dwait = mem_dwait;

	bus_request_decode u_decode (
		.c0(cp[0]),
		.c1(cp[1]),
		.requester(requester),
		.txn(txn),
		.pending(pending)
	);

	bus_control u_seq (
		.CLK(CLK),
		.nRST(nRST),
		.c0(cp[0]),
		.c1(cp[1]),
		.mem(mif),
		.requester(requester),
		.pending(pending),
		.txn(txn),
		.capture(capture),
		.complete(complete),
		.served(served)
	);

	bus_reply u_reply (
		.CLK(CLK),
		.nRST(nRST),
		.capture(capture),
		.complete(complete),
		.served(served),
		.mem_dload(mif.dload),
		.dload0(rep_dload0),
		.dload1(rep_dload1),
		.rdone0(rdone0),
		.rdone1(rdone1)
	);

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# compile and run the coherence bus testbench with Verilator, then scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f list.f --top-module tb_coherence_bus \
	-o tb_coherence_bus && ./obj_dir/tb_coherence_bus > sim.log 2>&1
[ -f sim.log ] && cat sim.log
[ -f sim.log ] || { echo "no simulation log, build failed"; exit 1; }
grep -q "TEST FAIL" sim.log && { echo "simulation reported a failure"; exit 1; }
grep -q "TEST PASS" sim.log || { echo "simulation ended without a pass line"; exit 1; }
exit 0

//--- sim/tb_coherence_bus.sv
`timescale 1ns/1ps
`default_nettype none

module tb_coherence_bus;
	import bus_pkg::*;

	localparam int TIMEOUT_CYCLES = 60;

	typedef enum logic [1:0] {
		K_READ,
		K_WB,
		K_INV
	} kind_t;

	// blk[0] sits at the block base, blk[1] one word above
	typedef struct packed {
		logic cache;
		kind_t kind;
		word_t addr;
		word_t store;
		logic modified;
		logic [1:0][31:0] blk;
		word_t exp_dload;
		logic [1:0] exp_inv;
	} row_t;

	logic CLK;
	logic nRST;
	logic dREN0, dWEN0, ccwrite0, cctrans0;
	logic dwait0, ccwait0, ccinv0;
	word_t daddr0, dstore0, dload0, ccsnoopaddr0;
	logic dREN1, dWEN1, ccwrite1, cctrans1;
	logic dwait1, ccwait1, ccinv1;
	word_t daddr1, dstore1, dload1, ccsnoopaddr1;
	logic mem_dREN, mem_dWEN, mem_dwait;
	word_t mem_daddr, mem_dstore, mem_dload;

	// memory model state
	word_t mem_words [word_t];
	logic [15:0] lfsr;
	int mem_delay;
	logic mem_ack;
	word_t mem_addr_q;

	row_t rows [$];
	string row_names [$];

	coherence_bus_top dut (.*);

	initial begin
		CLK = 1'b0;
		forever #20 CLK = ~CLK;
	end

	// Fibonacci LFSR, taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	// two bits per draw, so 0 to 3 extra wait cycles
	task automatic draw_delay(output int d);
		d = 0;
		repeat (2) begin
			lfsr = lfsr_next(lfsr);
			d = d * 2 + (lfsr[0] ? 1 : 0);
		end
	endtask

	// untouched memory returns its address with a marker in the top half
	function automatic word_t fill_word(input word_t a);
		return a ^ 32'h5A5A_0000;
	endfunction

	function automatic word_t mem_peek(input word_t a);
		if (mem_words.exists(a)) begin
			return mem_words[a];
		end
		return fill_word(a);
	endfunction

	function automatic logic dwait_of(input logic c);
		return c ? dwait1 : dwait0;
	endfunction

	function automatic logic ccwait_of(input logic c);
		return c ? ccwait1 : ccwait0;
	endfunction

	function automatic word_t dload_of(input logic c);
		return c ? dload1 : dload0;
	endfunction

	task automatic report_fail(input string msg);
		$display("%s", msg);
		$display("TEST FAIL");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_value(input string name, input string what, input word_t exp,
			input word_t act);
		assert (exp === act)
		else report_fail($sformatf("mismatch %s %s: expected %h, actual %h",
			name, what, exp, act));
	endtask

	task automatic drive_cache(input logic c, input logic ren, input logic wen,
			input logic ccw, input logic trans, input word_t addr, input word_t store);
		if (c) begin
			dREN1 = ren;
			dWEN1 = wen;
			ccwrite1 = ccw;
			cctrans1 = trans;
			daddr1 = addr;
			dstore1 = store;
		end else begin
			dREN0 = ren;
			dWEN0 = wen;
			ccwrite0 = ccw;
			cctrans0 = trans;
			daddr0 = addr;
			dstore0 = store;
		end
	endtask

	// memory accepts after a random wait, then drops dwait for one cycle
	always begin
		@(negedge CLK);
		mem_ack = 1'b0;
		mem_addr_q = mem_daddr;
		if (nRST && !mem_dwait && mem_dWEN) begin
			mem_words[mem_daddr] = mem_dstore;
		end else if (nRST && mem_dwait && (mem_dREN || mem_dWEN)) begin
			if (mem_delay == 0) begin
				mem_ack = 1'b1;
			end else begin
				mem_delay = mem_delay - 1;
			end
		end
		@(posedge CLK);
		#2;
		if (mem_ack) begin
			mem_dload = mem_peek(mem_addr_q);
			mem_dwait = 1'b0;
		end else begin
			if (!mem_dwait) begin
				draw_delay(mem_delay);
			end
			mem_dwait = 1'b1;
		end
	end

	task automatic add_row(input string name, input logic cache, input kind_t kind,
			input word_t addr, input word_t store, input logic modified,
			input logic [63:0] blk, input word_t exp_dload, input logic [1:0] exp_inv);
		row_t r;
		r.cache = cache;
		r.kind = kind;
		r.addr = addr;
		r.store = store;
		r.modified = modified;
		r.blk = blk;
		r.exp_dload = exp_dload;
		r.exp_inv = exp_inv;
		rows.push_back(r);
		row_names.push_back(name);
	endtask

	task automatic load_table();
		add_row("rd_clean_c0", 1'b0, K_READ, 32'h40, 32'h0, 1'b0, 64'h0, 32'h5A5A0040, 2'b00);
		add_row("rd_clean_c1", 1'b1, K_READ, 32'h44, 32'h0, 1'b0, 64'h0, 32'h5A5A0044, 2'b00);
		add_row("wb_c1", 1'b1, K_WB, 32'h80, 32'hCAFE0080, 1'b0, 64'h0, 32'h0, 2'b00);
		add_row("rd_after_wb_c0", 1'b0, K_READ, 32'h80, 32'h0, 1'b0, 64'h0,
			32'hCAFE0080, 2'b00);
		add_row("rd_hit_mod_c0", 1'b0, K_READ, 32'h10C, 32'h0, 1'b1,
			{32'h1111010C, 32'h11110108}, 32'h1111010C, 2'b10);
		add_row("rd_flushed_c1", 1'b1, K_READ, 32'h108, 32'h0, 1'b0, 64'h0,
			32'h11110108, 2'b00);
		add_row("rd_hit_mod_c1", 1'b1, K_READ, 32'h200, 32'h0, 1'b1,
			{32'h22220204, 32'h22220200}, 32'h22220200, 2'b01);
		add_row("inv_clean_c1", 1'b1, K_INV, 32'h300, 32'h33330300, 1'b0, 64'h0, 32'h0, 2'b01);
		add_row("inv_clean_c0", 1'b0, K_INV, 32'h304, 32'h33330304, 1'b0, 64'h0, 32'h0, 2'b10);
		add_row("inv_dirty_c0", 1'b0, K_INV, 32'h500, 32'h0, 1'b1,
			{32'h55550504, 32'h55550500}, 32'h0, 2'b10);
		add_row("wb_c0", 1'b0, K_WB, 32'h600, 32'h66660600, 1'b0, 64'h0, 32'h0, 2'b00);
		add_row("rd_after_inv_c0", 1'b0, K_READ, 32'h504, 32'h0, 1'b0, 64'h0,
			32'h55550504, 2'b00);
		add_row("rd_after_wb_c1", 1'b1, K_READ, 32'h600, 32'h0, 1'b0, 64'h0,
			32'h66660600, 2'b00);
	endtask

	task automatic check_reset_idle();
		@(negedge CLK);
		assert (dwait0 && dwait1 && !mem_dREN && !mem_dWEN && !ccinv0 && !ccinv1)
		else report_fail("bus outputs are not idle after reset");
		@(posedge CLK);
		#2;
	endtask

	// one table row from request to release, then the checks
	task automatic apply_row(input string name, input row_t r);
		logic other;
		logic done;
		logic advance;
		logic mem_used;
		logic [1:0] inv_seen;
		int wb_idx;
		int cycles;
		int busy;
		word_t base;
		word_t got;
		other = ~r.cache;
		base = r.addr & ~32'h7;
		done = 1'b0;
		mem_used = 1'b0;
		inv_seen = 2'b00;
		wb_idx = 0;
		cycles = 0;
		busy = 0;
		got = '0;
		drive_cache(r.cache, r.kind == K_READ, r.kind == K_WB, r.kind == K_INV, 1'b0,
			r.addr, r.store);
		// dirty copy answers the snoop with its first block word
		if (r.modified) begin
			drive_cache(other, 1'b0, 1'b0, 1'b0, 1'b1, base, r.blk[0]);
		end
		while (!done) begin
			@(negedge CLK);
			inv_seen = inv_seen | {ccinv1, ccinv0};
			mem_used = mem_used | mem_dREN | mem_dWEN;
			if (ccwait_of(other)) begin
				// first busy cycle of a read or invalidate is the snoop
				if (busy == 0 && r.kind != K_WB) begin
					check_value(name, "ccsnoopaddr0", r.addr, ccsnoopaddr0);
					check_value(name, "ccsnoopaddr1", r.addr, ccsnoopaddr1);
				end
				busy++;
			end
			assert (!ccwait_of(r.cache))
			else report_fail($sformatf("%s: ccwait went high to the requesting cache %0d",
				name, r.cache));
			advance = r.modified && !dwait_of(other);
			if (!dwait_of(r.cache)) begin
				done = 1'b1;
				got = dload_of(r.cache);
			end
			cycles++;
			assert (cycles < TIMEOUT_CYCLES)
			else report_fail($sformatf("timeout in %s waiting for cache %0d to be released",
				name, r.cache));
			@(posedge CLK);
			#2;
			if (advance) begin
				wb_idx++;
				if (wb_idx < BLOCK_WORDS) begin
					drive_cache(other, 1'b0, 1'b0, 1'b0, 1'b1, base + 32'h4, r.blk[1]);
				end else begin
					drive_cache(other, 1'b0, 1'b0, 1'b0, 1'b0, '0, '0);
				end
			end
			if (done) begin
				drive_cache(r.cache, 1'b0, 1'b0, 1'b0, 1'b0, '0, '0);
			end
		end
		assert (busy > 0)
		else report_fail($sformatf("%s: ccwait to cache %0d never went high", name, other));
		if (r.kind == K_READ) begin
			check_value(name, "dload", r.exp_dload, got);
		end
		check_value(name, "ccinv targets", 32'(r.exp_inv), 32'(inv_seen));
		if (r.kind == K_WB) begin
			check_value(name, "stored word", r.store, mem_peek(r.addr));
		end
		if (r.modified) begin
			check_value(name, "flushed word 0", r.blk[0], mem_peek(base));
			check_value(name, "flushed word 1", r.blk[1], mem_peek(base + 32'h4));
		end
		if (r.kind == K_INV && !r.modified) begin
			assert (!mem_used)
			else report_fail($sformatf("%s: clean invalidate used the memory port", name));
		end
	endtask

	// both caches read at once, cache 0 goes first
	task automatic check_priority();
		logic done0;
		logic done1;
		int cycles;
		word_t got0;
		word_t got1;
		done0 = 1'b0;
		done1 = 1'b0;
		cycles = 0;
		got0 = '0;
		got1 = '0;
		drive_cache(1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 32'h400, 32'h0);
		drive_cache(1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 32'h80, 32'h0);
		while (!(done0 && done1)) begin
			@(negedge CLK);
			if (!done0) begin
				assert (dwait1)
				else report_fail("cache 1 was released while cache 0 was still served");
				// first cycle is still IDLE
				assert (cycles == 0 || ccwait1)
				else report_fail("ccwait to cache 1 was low while cache 0 was served");
				if (!dwait0) begin
					done0 = 1'b1;
					got0 = dload0;
				end
			end else if (!dwait1) begin
				done1 = 1'b1;
				got1 = dload1;
			end
			cycles++;
			assert (cycles < 2 * TIMEOUT_CYCLES)
			else report_fail("timeout waiting for both caches in the priority test");
			@(posedge CLK);
			#2;
			if (done0) begin
				drive_cache(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, '0, '0);
			end
			if (done1) begin
				drive_cache(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, '0, '0);
			end
		end
		check_value("priority", "cache 0 dload", fill_word(32'h400), got0);
		check_value("priority", "cache 1 dload", 32'hCAFE0080, got1);
	endtask

	initial begin
		int i;
		nRST = 1'b0;
		drive_cache(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, '0, '0);
		drive_cache(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, '0, '0);
		mem_dwait = 1'b1;
		mem_dload = '0;
		lfsr = 16'd44434;
		draw_delay(mem_delay);
		load_table();
		repeat (16) @(posedge CLK);
		#2;
		nRST = 1'b1;
		check_reset_idle();
		for (i = 0; i < rows.size(); i++) begin
			apply_row(row_names[i], rows[i]);
		end
		check_priority();
		$display("TEST PASS");
		$finish;
	end

endmodule

`default_nettype wire
